//--- include/qr_params.svh
`ifndef QR_PARAMS_SVH
`define QR_PARAMS_SVH

// stored window, a square cut from the 640x480 camera frame
`define QR_WIDTH  480
`define QR_HEIGHT 480

// one bit per stored pixel
`define QR_DEPTH  230400

// frame address, enough for QR_DEPTH entries
`define QR_ADDR_W 18

// census counters, each can reach QR_DEPTH
`define QR_CNT_W  18

// frame store read latency in cycles
// address register plus output register
`define QR_RAM_LAT 2

`endif

//--- hw/cam_pkg.sv
`include "qr_params.svh"

package cam_pkg;

  // raw 5-6-5 camera pixel, red in the top bits
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef logic [10:0] hcount_t;  // column, camera is 640 wide
  typedef logic [9:0]  vcount_t;  // row, camera is 480 tall

  // one recovered camera beat with its position
  typedef struct packed {
    logic    valid;   // single-cycle strobe per pixel
    rgb565_t px;
    hcount_t hcount;
    vcount_t vcount;
  } cam_px_t;

  // row * QR_WIDTH + column
  typedef logic [`QR_ADDR_W-1:0] fb_addr_t;

endpackage

//--- hw/decode_pkg.sv
`include "qr_params.svh"

package decode_pkg;

  // top level decode progress
  typedef enum logic [1:0] {
    STREAMING = 2'd0,  // camera writes, display reads
    COUNTING  = 2'd1,  // census owns the read port
    FINISHED  = 2'd2   // result held until reset
  } decode_state_t;

  // census of the frozen frame
  typedef struct packed {
    logic [`QR_CNT_W-1:0] black_count;
    logic [`QR_CNT_W-1:0] white_count;
  } census_t;

  // one display pixel after the rotated lookup
  typedef struct packed {
    logic valid;  // point in window and port granted
    logic pixel;  // stored bit, 1 is white
  } disp_px_t;

endpackage

//--- hw/cam_binarize.sv
`timescale 1ns/10ps
`include "qr_params.svh"

module cam_binarize
  import cam_pkg::*;
(
  input  logic       clk_pixel,
  input  logic       sys_rst,
  input  cam_px_t    cam_in,     // recovered camera beat
  input  logic [7:0] threshold,  // gray split level
  input  logic       freeze,     // stored frame is held
  output logic       wr_en,      // write strobe into frame store
  output fb_addr_t   wr_addr,
  output logic       wr_bit      // 1 white, 0 black
);

  logic [7:0] red8;
  logic [7:0] green8;
  logic [7:0] blue8;
  logic [9:0] gray_sum;   // r + 2g + b, max 1000

  logic       s1_vld;     // beat lands inside the 480x480 window
  logic [7:0] s1_gray;
  hcount_t    s1_hcount;  // column in step with the gray value
  vcount_t    s1_vcount;

  // fill each channel up to 8 bits
  assign red8   = {cam_in.px.red, 3'b000};
  assign green8 = {cam_in.px.green, 2'b00};
  assign blue8  = {cam_in.px.blue, 3'b000};

  assign gray_sum = {2'b00, red8} + {1'b0, green8, 1'b0} + {2'b00, blue8};

  // stage one, gray and window test
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= cam_in.valid && (cam_in.hcount < `QR_WIDTH) && (cam_in.vcount < `QR_HEIGHT);
    end
  end

  always_ff @(posedge clk_pixel) begin
    s1_gray   <= gray_sum[9:2];  // divide by four
    s1_hcount <= cam_in.hcount;
    s1_vcount <= cam_in.vcount;
  end

  // stage two, threshold, address, strobe
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= s1_vld && !freeze;  // frozen beats are dropped
    end
  end

  always_ff @(posedge clk_pixel) begin
    wr_bit  <= (s1_gray > threshold);  // strictly above is white
    wr_addr <= fb_addr_t'(s1_vcount) * fb_addr_t'(`QR_WIDTH) + fb_addr_t'(s1_hcount);
  end

  // row and column limits keep every write inside the store
  a_wr_in_range: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    wr_en |-> (wr_addr < `QR_DEPTH));

endmodule

//--- hw/frame_store.sv
`timescale 1ns/10ps
`include "qr_params.svh"

module frame_store
  import cam_pkg::*;
(
  input  logic     clk_pixel,
  input  logic     wr_en,    // camera side write strobe
  input  fb_addr_t wr_addr,
  input  logic     wr_bit,
  input  fb_addr_t rd_addr,  // granted reader address
  output logic     rd_bit    // valid QR_RAM_LAT cycles after rd_addr
);

  // one bit per pixel of the stored window
  logic mem [0:`QR_DEPTH-1];

  fb_addr_t rd_addr_q;  // registered read address

  // write port
  always_ff @(posedge clk_pixel) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_bit;
    end
  end

  // read port always enabled, two registers deep
  // a read of the address being written returns the old bit
  always_ff @(posedge clk_pixel) begin
    rd_addr_q <= rd_addr;
    rd_bit    <= mem[rd_addr_q];  // output register
  end

endmodule

//--- hw/display_addr.sv
`timescale 1ns/10ps
`include "qr_params.svh"

module display_addr
  import cam_pkg::*;
  import decode_pkg::*;
(
  input  logic     clk_pixel,
  input  logic     sys_rst,
  input  hcount_t  disp_hcount,   // dx
  input  vcount_t  disp_vcount,   // dy
  input  logic     disp_grant,    // read port belongs to the display
  input  logic     rd_bit,        // frame store data
  output fb_addr_t disp_rd_addr,  // rotated lookup address
  output disp_px_t disp_out
);

  logic                   in_win;    // point falls on the stored square
  fb_addr_t               rot_row;   // QR_WIDTH-1-dx
  logic                   addr_vld;  // valid beside disp_rd_addr
  logic [`QR_RAM_LAT-1:0] vld_pipe;  // follows the read through the store

  assign in_win  = (disp_hcount < `QR_WIDTH) && (disp_vcount < `QR_HEIGHT);
  assign rot_row = fb_addr_t'(`QR_WIDTH - 1) - fb_addr_t'(disp_hcount);

  // quarter turn, point (dx, dy) reads column dy of row 479-dx
  always_ff @(posedge clk_pixel) begin
    disp_rd_addr <= rot_row * fb_addr_t'(`QR_WIDTH) + fb_addr_t'(disp_vcount);
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      addr_vld <= 1'b0;
      vld_pipe <= '0;
    end else begin
      addr_vld <= in_win && disp_grant;
      vld_pipe <= {vld_pipe[`QR_RAM_LAT-2:0], addr_vld};  // match the ram latency
    end
  end

  // pixel forced low when the lookup was not valid
  assign disp_out.valid = vld_pipe[`QR_RAM_LAT-1];
  assign disp_out.pixel = vld_pipe[`QR_RAM_LAT-1] & rd_bit;

  // a lit pixel needs a granted lookup issued three cycles before
  a_disp_masked: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    disp_out.pixel |-> disp_out.valid && $past(disp_grant, `QR_RAM_LAT + 1));

endmodule

//--- hw/pixel_census.sv
`timescale 1ns/10ps
`include "qr_params.svh"

module pixel_census
  import cam_pkg::*;
  import decode_pkg::*;
(
  input  logic     clk_pixel,
  input  logic     sys_rst,
  input  logic     census_start,    // one-cycle pulse from the FSM
  input  logic     rd_bit,          // frame store data
  output fb_addr_t census_rd_addr,  // scan address, one per cycle
  output logic     census_done,     // one-cycle pulse, counts final
  output census_t  census
);

  logic                   scanning;   // census_rd_addr holds a live address
  logic                   last_addr;  // final address of the frame
  logic [`QR_RAM_LAT-1:0] vld_pipe;   // rd_bit belongs to the scan
  logic [`QR_RAM_LAT-1:0] last_pipe;  // rd_bit is the final pixel

  assign last_addr = scanning && (census_rd_addr == fb_addr_t'(`QR_DEPTH - 1));

  // address walk 0 .. QR_DEPTH-1
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      scanning       <= 1'b0;
      census_rd_addr <= '0;
    end else if (census_start) begin
      scanning       <= 1'b1;
      census_rd_addr <= '0;
    end else if (scanning) begin
      scanning       <= !last_addr;  // stop after the final address
      census_rd_addr <= census_rd_addr + 1'b1;
    end
  end

  // track each address through the read latency
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      vld_pipe  <= '0;
      last_pipe <= '0;
    end else begin
      vld_pipe  <= {vld_pipe[`QR_RAM_LAT-2:0], scanning};
      last_pipe <= {last_pipe[`QR_RAM_LAT-2:0], last_addr};
    end
  end

  // counters
  always_ff @(posedge clk_pixel) begin
    if (sys_rst || census_start) begin
      census <= '0;
    end else if (vld_pipe[`QR_RAM_LAT-1]) begin
      if (rd_bit) begin
        census.white_count <= census.white_count + 1'b1;
      end else begin
        census.black_count <= census.black_count + 1'b1;
      end
    end
  end

  // done lands with the final count already in place
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      census_done <= 1'b0;
    end else begin
      census_done <= last_pipe[`QR_RAM_LAT-1];
    end
  end

  // every address of the window was read and counted exactly once
  a_census_total: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    census_done |-> (census.black_count + census.white_count == `QR_DEPTH));

endmodule

//--- hw/decode_ctrl.sv
`timescale 1ns/10ps

module decode_ctrl
  import cam_pkg::*;
  import decode_pkg::*;
(
  input  logic       clk_pixel,
  input  logic       sys_rst,
  input  logic       capture,         // hold the current frame
  input  logic       start,           // begin the census
  input  logic       census_done,
  input  census_t    census,
  input  fb_addr_t   disp_rd_addr,
  input  fb_addr_t   census_rd_addr,
  output logic       freeze,          // blocks camera writes
  output logic       disp_grant,
  output logic       census_start,    // one-cycle pulse
  output fb_addr_t   rd_addr,         // shared frame store read port
  output census_t    census_out,
  output logic       census_valid,
  output logic [2:0] stage_led        // one-hot per state
);

  decode_state_t state;

  // FSM, FINISHED is left only through reset
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state        <= STREAMING;
      census_start <= 1'b0;
    end else begin
      census_start <= 1'b0;
      case (state)
        STREAMING: begin
          if (capture && start) begin
            state        <= COUNTING;
            census_start <= 1'b1;  // fires once on entry
          end
        end
        COUNTING: begin
          if (census_done) begin
            state <= FINISHED;
          end
        end
        default: state <= state;  // FINISHED holds
      endcase
    end
  end

  // result latch
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      census_out   <= '0;
      census_valid <= 1'b0;
    end else if (census_done) begin
      census_out   <= census;
      census_valid <= 1'b1;
    end
  end

  assign freeze     = capture || (state != STREAMING);
  assign disp_grant = (state != COUNTING);  // display reads except during the scan

  // read port mux, census wins while counting
  assign rd_addr = (state == COUNTING) ? census_rd_addr : disp_rd_addr;

  always_comb begin
    case (state)
      STREAMING: stage_led = 3'b001;
      COUNTING:  stage_led = 3'b010;
      FINISHED:  stage_led = 3'b100;
      default:   stage_led = 3'b000;
    endcase
  end

  // census never finishes outside its own scan
  a_done_in_counting: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    census_done |-> (state == COUNTING));

endmodule

//--- hw/qr_top.sv
`timescale 1ns/10ps

module qr_top
  import cam_pkg::*;
  import decode_pkg::*;
(
  input  logic       clk_pixel,
  input  logic       sys_rst,
  input  cam_px_t    cam_in,        // recovered camera stream
  input  logic [7:0] threshold,
  input  logic       capture,
  input  logic       start,
  input  hcount_t    disp_hcount,
  input  vcount_t    disp_vcount,
  output disp_px_t   disp_out,      // three cycles after the coordinates
  output census_t    census_out,
  output logic       census_valid,
  output logic [2:0] stage_led
);

  logic     wr_en;           // binarizer to frame store
  fb_addr_t wr_addr;
  logic     wr_bit;
  logic     freeze;
  fb_addr_t rd_addr;         // arbitrated read port
  logic     rd_bit;
  fb_addr_t disp_rd_addr;
  fb_addr_t census_rd_addr;
  logic     disp_grant;
  logic     census_start;
  logic     census_done;
  census_t  census;          // live counts from the scan

  cam_binarize u_cam_binarize (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .cam_in    (cam_in),
    .threshold (threshold),
    .freeze    (freeze),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_bit    (wr_bit)
  );

  frame_store u_frame_store (
    .clk_pixel (clk_pixel),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_bit    (wr_bit),
    .rd_addr   (rd_addr),
    .rd_bit    (rd_bit)
  );

  display_addr u_display_addr (
    .clk_pixel    (clk_pixel),
    .sys_rst      (sys_rst),
    .disp_hcount  (disp_hcount),
    .disp_vcount  (disp_vcount),
    .disp_grant   (disp_grant),
    .rd_bit       (rd_bit),
    .disp_rd_addr (disp_rd_addr),
    .disp_out     (disp_out)
  );

  pixel_census u_pixel_census (
    .clk_pixel      (clk_pixel),
    .sys_rst        (sys_rst),
    .census_start   (census_start),
    .rd_bit         (rd_bit),
    .census_rd_addr (census_rd_addr),
    .census_done    (census_done),
    .census         (census)
  );

  decode_ctrl u_decode_ctrl (
    .clk_pixel      (clk_pixel),
    .sys_rst        (sys_rst),
    .capture        (capture),
    .start          (start),
    .census_done    (census_done),
    .census         (census),
    .disp_rd_addr   (disp_rd_addr),
    .census_rd_addr (census_rd_addr),
    .freeze         (freeze),
    .disp_grant     (disp_grant),
    .census_start   (census_start),
    .rd_addr        (rd_addr),
    .census_out     (census_out),
    .census_valid   (census_valid),
    .stage_led      (stage_led)
  );

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/10ps

// free running pixel clock, 20 ns period
module tb_clkgen (
  output logic clk_pixel
);

  initial begin
    clk_pixel = 1'b0;
    forever begin
      #10 clk_pixel = ~clk_pixel;  // half period
    end
  end

endmodule

//--- testbench/tb_qr_top.sv
`timescale 1ns/10ps
`include "qr_params.svh"

module tb_qr_top
  import cam_pkg::*;
  import decode_pkg::*;
;

  localparam int          NUM_TESTS      = 5;
  localparam int          CAM_W          = 640;  // full camera line
  localparam int          CAM_H          = 480;
  localparam int          NUM_PROBES     = 200;  // display points per probe pass
  localparam int          CENSUS_TIMEOUT = `QR_DEPTH + 100;
  localparam logic [31:0] SEED           = 32'h18cb_3bd4;
  localparam logic [1:0]  KIND_SOLID     = 2'd0;
  localparam logic [1:0]  KIND_CHECKER   = 2'd1;
  localparam logic [1:0]  KIND_RANDOM    = 2'd2;
  localparam int          CORNER_X [6]   = '{0, 479, 479, 0, 480, 0};  // edges of the window
  localparam int          CORNER_Y [6]   = '{0, 479, 0, 479, 0, 480};

  // exp_white below zero means take it from the model
  typedef struct packed {
    logic [1:0]  kind;
    logic [15:0] color;
    logic [7:0]  thresh;
    int          exp_white;
  } test_row_t;

  logic       clk_pixel;
  logic       sys_rst;
  cam_px_t    cam_in;
  logic [7:0] threshold;
  logic       capture;
  logic       start;
  hcount_t    disp_hcount;
  vcount_t    disp_vcount;
  disp_px_t   disp_out;
  census_t    census_out;
  logic       census_valid;
  logic [2:0] stage_led;

  string     row_name [NUM_TESTS];
  test_row_t rows [NUM_TESTS];
  bit        ref_frame [0:`QR_DEPTH-1];  // model of the stored window
  int        ref_white;
  int        ref_black;
  string     cur_name;
  int        errors;
  int        n_pass;
  int        n_fail;
  bit        timed_out;

  tb_clkgen u_clkgen (.clk_pixel(clk_pixel));

  qr_top u_qr_top (
    .clk_pixel    (clk_pixel),
    .sys_rst      (sys_rst),
    .cam_in       (cam_in),
    .threshold    (threshold),
    .capture      (capture),
    .start        (start),
    .disp_hcount  (disp_hcount),
    .disp_vcount  (disp_vcount),
    .disp_out     (disp_out),
    .census_out   (census_out),
    .census_valid (census_valid),
    .stage_led    (stage_led)
  );

  task automatic load_table();
    row_name[0] = "solid_below";   // gray 128 against 127 gives all white
    rows[0]     = '{KIND_SOLID, 16'h8410, 8'd127, `QR_DEPTH};
    row_name[1] = "solid_equal";   // equal is not above
    rows[1]     = '{KIND_SOLID, 16'h8410, 8'd128, 0};
    row_name[2] = "solid_above";
    rows[2]     = '{KIND_SOLID, 16'h8410, 8'd129, 0};
    row_name[3] = "checkerboard";  // white on odd x+y
    rows[3]     = '{KIND_CHECKER, 16'hffff, 8'd100, `QR_DEPTH / 2};
    row_name[4] = "random";
    rows[4]     = '{KIND_RANDOM, 16'h0000, 8'd128, -1};
  endtask

  task automatic report_mismatch(input string what, input int expected, input int actual);
    $display("FAILED %s %s: expected %0d, actual %0d", cur_name, what, expected, actual);
    errors++;
  endtask

  // gray from the 5-6-5 channels each filled out to 8 bits
  function automatic int gray_level(input rgb565_t px);
    int r8;
    int g8;
    int b8;
    r8 = int'(px.red) * 8;
    g8 = int'(px.green) * 4;
    b8 = int'(px.blue) * 8;
    return (r8 + 2 * g8 + b8) / 4;
  endfunction

  function automatic rgb565_t make_pixel(input test_row_t row, input int x, input int y,
                                         input bit second);
    rgb565_t     px;
    logic [31:0] rnd;
    rnd = $urandom;
    case (row.kind)
      KIND_CHECKER: px = ((x + y) % 2 == 1) ? row.color : ~row.color;
      KIND_RANDOM:  px = rnd[15:0];  // fresh noise every beat
      default:      px = row.color;
    endcase
    if (second) begin
      px = ~px;  // second frame differs from the first
    end
    return px;
  endfunction

  // point (dx, dy) shows column dy of row 479-dx
  function automatic logic [1:0] expected_disp(input int dx, input int dy);
    if (dx < `QR_WIDTH && dy < `QR_HEIGHT) begin
      return {1'b1, ref_frame[(`QR_WIDTH - 1 - dx) * `QR_WIDTH + dy]};
    end
    return 2'b00;  // invalid and dark outside the window
  endfunction

  task automatic park_display();
    disp_hcount = 11'h7ff;  // far outside the window
    disp_vcount = 10'h3ff;
  endtask

  task automatic reset_dut();
    sys_rst     = 1'b1;
    capture     = 1'b0;
    start       = 1'b0;
    cam_in      = '0;
    disp_hcount = hcount_t'(0);  // in the window so only reset keeps valid low
    disp_vcount = vcount_t'(0);
    repeat (4) begin
      @(posedge clk_pixel);
      #1;
    end
    sys_rst = 1'b0;
    if (stage_led !== 3'b001) report_mismatch("stage_led after reset", 1, int'(stage_led));
    if (census_valid !== 1'b0) begin
      report_mismatch("census_valid after reset", 0, int'(census_valid));
    end
    if (disp_out.valid !== 1'b0) begin
      report_mismatch("disp_out.valid after reset", 0, int'(disp_out.valid));
    end
    if (census_out.white_count !== '0) begin
      report_mismatch("white count after reset", 0, int'(census_out.white_count));
    end
    if (census_out.black_count !== '0) begin
      report_mismatch("black count after reset", 0, int'(census_out.black_count));
    end
    park_display();
  endtask

  // one beat per cycle with the model updated only for the first frame
  task automatic stream_frame(input test_row_t row, input bit second);
    rgb565_t px;
    int      addr;
    for (int y = 0; y < CAM_H; y++) begin
      for (int x = 0; x < CAM_W; x++) begin
        px            = make_pixel(row, x, y, second);
        cam_in.valid  = 1'b1;
        cam_in.px     = px;
        cam_in.hcount = hcount_t'(x);
        cam_in.vcount = vcount_t'(y);
        if (!second && x < `QR_WIDTH && y < `QR_HEIGHT) begin
          addr            = y * `QR_WIDTH + x;
          ref_frame[addr] = (gray_level(px) > int'(row.thresh));
          if (ref_frame[addr]) ref_white++;
          else ref_black++;
        end
        @(posedge clk_pixel);
        #1;
      end
    end
    cam_in.valid = 1'b0;
  endtask

  // one point per cycle and each result checked three cycles later
  task automatic probe_display(input string phase);
    logic [1:0] expect_q [$];
    int         qx [$];
    int         qy [$];
    logic [1:0] exp_px;
    int         px_x;
    int         px_y;
    int         dx;
    int         dy;
    for (int i = 0; i < NUM_PROBES + 3; i++) begin
      if (i >= 3) begin
        exp_px = expect_q.pop_front();
        px_x   = qx.pop_front();
        px_y   = qy.pop_front();
        if (disp_out !== exp_px) begin
          report_mismatch($sformatf("%s display {valid,pixel} at (%0d,%0d)", phase, px_x, px_y),
                          int'(exp_px), int'(disp_out));
        end
      end
      if (i < NUM_PROBES) begin
        dx = (i < 6) ? CORNER_X[i] : int'($urandom_range(0, CAM_W - 1));
        dy = (i < 6) ? CORNER_Y[i] : int'($urandom_range(0, 511));
        disp_hcount = hcount_t'(dx);
        disp_vcount = vcount_t'(dy);
        expect_q.push_back(expected_disp(dx, dy));
        qx.push_back(dx);
        qy.push_back(dy);
      end else begin
        park_display();
      end
      @(posedge clk_pixel);
      #1;
    end
  endtask

  task automatic run_test(input test_row_t row);
    int wait_cycles;
    reset_dut();
    threshold = row.thresh;
    ref_white = 0;
    ref_black = 0;
    stream_frame(row, 1'b0);
    probe_display("live");
    capture = 1'b1;  // frame held from here on
    stream_frame(row, 1'b1);
    probe_display("frozen");
    start = 1'b1;
    @(posedge clk_pixel);
    #1;
    if (stage_led !== 3'b010) report_mismatch("stage_led counting", 2, int'(stage_led));
    wait_cycles = 0;
    while (census_valid !== 1'b1 && wait_cycles < CENSUS_TIMEOUT) begin
      @(posedge clk_pixel);
      #1;
      wait_cycles++;
    end
    if (census_valid !== 1'b1) begin
      $display("census_valid never rose within %0d cycles in test %s", CENSUS_TIMEOUT, cur_name);
      timed_out = 1'b1;
      return;
    end
    capture = 1'b0;
    start   = 1'b0;
    if (int'(census_out.white_count) != ref_white) begin
      report_mismatch("white count", ref_white, int'(census_out.white_count));
    end
    if (int'(census_out.black_count) != ref_black) begin
      report_mismatch("black count", ref_black, int'(census_out.black_count));
    end
    if (row.exp_white >= 0 && int'(census_out.white_count) != row.exp_white) begin
      report_mismatch("white count from table", row.exp_white, int'(census_out.white_count));
    end
    if (int'(census_out.white_count) + int'(census_out.black_count) != `QR_DEPTH) begin
      report_mismatch("count sum", `QR_DEPTH,
                      int'(census_out.white_count) + int'(census_out.black_count));
    end
    if (stage_led !== 3'b100) report_mismatch("stage_led finished", 4, int'(stage_led));
    probe_display("finished");
  endtask

  initial begin
    int errs_before;
    sys_rst   = 1'b1;
    cam_in    = '0;
    threshold = 8'd0;
    capture   = 1'b0;
    start     = 1'b0;
    park_display();
    errors    = 0;
    n_pass    = 0;
    n_fail    = 0;
    timed_out = 1'b0;
    void'($urandom(SEED));
    load_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_name    = row_name[t];
      errs_before = errors;
      run_test(rows[t]);
      if (timed_out || errors != errs_before) begin
        n_fail++;
        $display("test %s: %0d errors%s", cur_name, errors - errs_before,
                 timed_out ? ", stopped on timeout" : "");
      end else begin
        n_pass++;
        $display("test %s: ok", cur_name);
      end
      if (timed_out) break;
    end
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
hw/cam_pkg.sv
hw/decode_pkg.sv
hw/cam_binarize.sv
hw/frame_store.sv
hw/display_addr.sv
hw/pixel_census.sv
hw/decode_ctrl.sv
hw/qr_top.sv
testbench/tb_clkgen.sv
testbench/tb_qr_top.sv

//--- Makefile
TOP = tb_qr_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
